/* hdl/cdc_link_defs.svh */
`ifndef CDC_LINK_DEFS_SVH
`define CDC_LINK_DEFS_SVH

// width of the payload word carried across the link
`define CDC_DATA_BITS 8

// width of the sequence tag, wraps modulo 2**bits
`define CDC_SEQ_BITS 4

// destination cycles without a delivery before the link counts as stale
`define CDC_STALE_CYCLES 64

`endif

/* hdl/cdc_link_pkg.sv */
`include "cdc_link_defs.svh"

package cdc_link_pkg;

  // one tagged sample as it travels through the crossing
  // tag sits in the upper bits, payload word in the lower bits
  typedef struct packed {
    logic [`CDC_SEQ_BITS-1:0]  seq;
    logic [`CDC_DATA_BITS-1:0] data;
  } sample_t;

  // sender states
  // IDLE waits for a push, LOAD issues the strobe to the crossing,
  // WAIT holds until the crossing reports ready again
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    WAIT
  } send_state_t;

endpackage

/* hdl/handshake_cdc.sv */
`timescale 1ns/1ns

module handshake_cdc #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_src_i,
  input  logic     clk_dst_i,
  input  logic     rst_i,
  // source side
  input  logic     src_req_i,
  output logic     src_rdy_o,
  input  payload_t src_data_i,
  // destination side
  output logic     dst_req_o,
  output payload_t dst_data_o
);

  // source domain flops
  logic     src_req_q;
  logic     src_req_d;
  payload_t src_data_q;
  payload_t src_data_d;
  logic     ack_meta_q;
  logic     src_ack_q2;

  // destination domain flops
  logic     req_meta_q;
  logic     dst_req_q2;
  logic     dst_ack_q;

  // a strobe only counts while the previous transfer has come back
  always_comb begin
    src_req_d  = src_req_q;
    src_data_d = src_data_q;
    if (src_req_i && src_rdy_o) begin
      // hold the payload stable until the ack returns
      src_data_d = src_data_i;
      src_req_d  = ~src_req_q;
    end
  end

  always_ff @(posedge clk_src_i) begin
    if (rst_i) begin
      src_req_q  <= 1'b0;
      src_data_q <= '0;
      ack_meta_q <= 1'b0;
      src_ack_q2 <= 1'b0;
    end else begin
      src_req_q  <= src_req_d;
      src_data_q <= src_data_d;
      // ack toggle back into the source clock, two stages
      ack_meta_q <= dst_ack_q;
      src_ack_q2 <= ack_meta_q;
    end
  end

  always_ff @(posedge clk_dst_i) begin
    if (rst_i) begin
      req_meta_q <= 1'b0;
      dst_req_q2 <= 1'b0;
      dst_ack_q  <= 1'b0;
    end else begin
      // req toggle into the destination clock, two stages
      req_meta_q <= src_req_q;
      dst_req_q2 <= req_meta_q;
      // ack follows req one edge later, so dst_req_o lasts one cycle
      dst_ack_q  <= dst_req_q2;
    end
  end

  // idle once the returned ack matches the current req toggle
  assign src_rdy_o = (src_ack_q2 == src_req_q);

  // pending request seen on the destination side
  assign dst_req_o = (dst_req_q2 != dst_ack_q);

  // payload is stable while a request is pending
  assign dst_data_o = src_data_q;

endmodule

/* hdl/send_fsm.sv */
`timescale 1ns/1ns
`include "cdc_link_defs.svh"

module send_fsm (
  input  logic                      clk_src_i,
  input  logic                      rst_i,
  input  logic                      src_push_i,
  input  logic [`CDC_DATA_BITS-1:0] src_data_i,
  input  logic                      cdc_rdy_i,
  output logic                      src_ready_o,
  output logic                      cdc_req_o,
  output cdc_link_pkg::sample_t     cdc_payload_o,
  output logic [7:0]                src_drops_o
);

  import cdc_link_pkg::*;

  send_state_t              state_q;
  send_state_t              state_d;
  logic [`CDC_SEQ_BITS-1:0] seq_q;
  sample_t                  payload_q;
  logic [7:0]               drops_q;
  logic                     accept;
  logic                     drop;

  // ready only while idle and the crossing has no transfer in flight
  assign src_ready_o = (state_q == IDLE) && cdc_rdy_i;
  assign accept      = src_push_i && src_ready_o;
  assign drop        = src_push_i && !src_ready_o;

  // one-cycle strobe to the crossing
  assign cdc_req_o = (state_q == LOAD);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = LOAD;
        end
      end
      LOAD: begin
        state_d = WAIT;
      end
      WAIT: begin
        // rdy comes back once the ack toggle has returned
        if (cdc_rdy_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_src_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      seq_q   <= '0;
      drops_q <= '0;
    end else begin
      state_q <= state_d;
      // every push takes a tag, dropped ones too
      if (src_push_i) begin
        seq_q <= seq_q + 1'b1;
      end
      // drop count saturates at 255
      if (drop && (drops_q != 8'hff)) begin
        drops_q <= drops_q + 8'd1;
      end
    end
  end

  // tagged sample, held through LOAD and WAIT
  always_ff @(posedge clk_src_i) begin
    if (accept) begin
      payload_q.seq  <= seq_q;
      payload_q.data <= src_data_i;
    end
  end

  assign cdc_payload_o = payload_q;
  assign src_drops_o   = drops_q;

endmodule

/* hdl/stale_timer.sv */
`timescale 1ns/1ns

module stale_timer #(
  parameter int STALE_CYCLES = 64
) (
  input  logic clk_dst_i,
  input  logic rst_i,
  input  logic delivered_i,
  output logic stale_o
);

  localparam int CNT_BITS = $clog2(STALE_CYCLES + 1);
  localparam logic [CNT_BITS-1:0] CNT_LIMIT = CNT_BITS'(STALE_CYCLES);
  localparam logic [CNT_BITS-1:0] CNT_ONE = CNT_BITS'(1);

  // cycles since the last delivery pulse began
  logic [CNT_BITS-1:0] count_q;

  always_ff @(posedge clk_dst_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (delivered_i) begin
      // the pulse cycle itself is the first quiet cycle counted
      count_q <= CNT_ONE;
    end else if (count_q != CNT_LIMIT) begin
      count_q <= count_q + CNT_ONE;
    end
  end

  // flag holds while the count sits at the limit
  assign stale_o = (count_q == CNT_LIMIT);

endmodule

/* hdl/dst_capture.sv */
`timescale 1ns/1ns
`include "cdc_link_defs.svh"

module dst_capture (
  input  logic                      clk_dst_i,
  input  logic                      rst_i,
  input  logic                      dst_req_i,
  input  cdc_link_pkg::sample_t     dst_sample_i,
  output logic                      dst_valid_o,
  output logic [`CDC_DATA_BITS-1:0] dst_data_o,
  output logic [`CDC_SEQ_BITS-1:0]  dst_seq_o,
  output logic [7:0]                dst_lost_o
);

  logic                      valid_q;
  logic [`CDC_DATA_BITS-1:0] data_q;
  logic [`CDC_SEQ_BITS-1:0]  seq_q;
  // tag the next delivery should carry
  logic [`CDC_SEQ_BITS-1:0]  expect_q;
  logic [`CDC_SEQ_BITS-1:0]  gap;
  logic [7:0]                lost_q;

  // skipped tags, modulo the tag range
  assign gap = dst_sample_i.seq - expect_q;

  always_ff @(posedge clk_dst_i) begin
    if (rst_i) begin
      valid_q  <= 1'b0;
      expect_q <= '0;
      lost_q   <= '0;
    end else begin
      // dst_req_i is high for one cycle per transfer
      valid_q <= dst_req_i;
      if (dst_req_i) begin
        expect_q <= dst_sample_i.seq + 1'b1;
        lost_q   <= lost_q + 8'(gap);
      end
    end
  end

  // delivered word and tag
  always_ff @(posedge clk_dst_i) begin
    if (dst_req_i) begin
      data_q <= dst_sample_i.data;
      seq_q  <= dst_sample_i.seq;
    end
  end

  assign dst_valid_o = valid_q;
  assign dst_data_o  = data_q;
  assign dst_seq_o   = seq_q;
  assign dst_lost_o  = lost_q;

endmodule

/* hdl/cdc_sample_link.sv */
`timescale 1ns/1ns
`include "cdc_link_defs.svh"

module cdc_sample_link (
  input  logic                      clk_src_i,
  input  logic                      clk_dst_i,
  input  logic                      rst_i,
  // source domain
  input  logic                      src_push_i,
  input  logic [`CDC_DATA_BITS-1:0] src_data_i,
  output logic                      src_ready_o,
  output logic [7:0]                src_drops_o,
  // destination domain
  output logic                      dst_valid_o,
  output logic [`CDC_DATA_BITS-1:0] dst_data_o,
  output logic [`CDC_SEQ_BITS-1:0]  dst_seq_o,
  output logic [7:0]                dst_lost_o,
  output logic                      dst_stale_o
);

  import cdc_link_pkg::*;

  // sender to crossing
  logic    cdc_req;
  logic    cdc_rdy;
  sample_t cdc_payload;
  // crossing to capture
  logic    dst_req;
  sample_t dst_sample;

  send_fsm u_send_fsm (
    .clk_src_i     (clk_src_i),
    .rst_i         (rst_i),
    .src_push_i    (src_push_i),
    .src_data_i    (src_data_i),
    .cdc_rdy_i     (cdc_rdy),
    .src_ready_o   (src_ready_o),
    .cdc_req_o     (cdc_req),
    .cdc_payload_o (cdc_payload),
    .src_drops_o   (src_drops_o)
  );

  handshake_cdc #(
    .payload_t (sample_t)
  ) u_handshake_cdc (
    .clk_src_i  (clk_src_i),
    .clk_dst_i  (clk_dst_i),
    .rst_i      (rst_i),
    .src_req_i  (cdc_req),
    .src_rdy_o  (cdc_rdy),
    .src_data_i (cdc_payload),
    .dst_req_o  (dst_req),
    .dst_data_o (dst_sample)
  );

  dst_capture u_dst_capture (
    .clk_dst_i    (clk_dst_i),
    .rst_i        (rst_i),
    .dst_req_i    (dst_req),
    .dst_sample_i (dst_sample),
    .dst_valid_o  (dst_valid_o),
    .dst_data_o   (dst_data_o),
    .dst_seq_o    (dst_seq_o),
    .dst_lost_o   (dst_lost_o)
  );

  // watchdog restarts on every delivery pulse
  stale_timer #(
    .STALE_CYCLES (`CDC_STALE_CYCLES)
  ) u_stale_timer (
    .clk_dst_i   (clk_dst_i),
    .rst_i       (rst_i),
    .delivered_i (dst_valid_o),
    .stale_o     (dst_stale_o)
  );

endmodule

/* tests/link_checker.sv */
`timescale 1ns/1ns
`include "cdc_link_defs.svh"

module link_checker (
  input logic                      clk_src_i,
  input logic                      clk_dst_i,
  input logic                      rst_i,
  input logic                      src_ready_i,
  input logic [7:0]                src_drops_i,
  input logic                      dst_valid_i,
  input logic [`CDC_DATA_BITS-1:0] dst_data_i,
  input logic [`CDC_SEQ_BITS-1:0]  dst_seq_i,
  input logic [7:0]                dst_lost_i,
  input logic                      dst_stale_i
);

  import cdc_link_pkg::*;

  // expected deliveries in push order
  sample_t exp_q[$];
  // drops the model saw just before each accepted push
  int      gap_q[$];
  string   cur_test = "none";
  int      err_count = 0;
  int      test_errs = 0;
  int      test_count = 0;
  int      accepted = 0;
  int      delivered = 0;
  int      exp_lost = 0;
  // destination cycles since the last delivery or reset as the watchdog should count them
  int      quiet = 0;

  task automatic compare(input string what, input int expected, input int actual);
    if (expected != actual) begin
      err_count++;
      $display("Error %s: %s expected %0d actual %0d", cur_test, what, expected, actual);
    end
  endtask

  task automatic expect_sample(input logic [`CDC_SEQ_BITS-1:0] seq,
                               input logic [`CDC_DATA_BITS-1:0] data, input int gap);
    sample_t s;
    s.seq  = seq;
    s.data = data;
    exp_q.push_back(s);
    gap_q.push_back(gap);
    accepted++;
  endtask

  always @(posedge clk_dst_i) begin : monitor
    sample_t s;
    if (rst_i) begin
      quiet = 0;
    end else begin
      // stale must follow the quiet count exactly in every test
      compare("dst_stale_o", (quiet >= `CDC_STALE_CYCLES) ? 1 : 0, int'(dst_stale_i));
      if (dst_valid_i) begin
        quiet = 1;
        delivered++;
        if (exp_q.size() == 0) begin
          err_count++;
          $display("%s: a word was delivered that was never accepted", cur_test);
        end else begin
          s = exp_q.pop_front();
          exp_lost += gap_q.pop_front();
          compare("dst_data_o", int'(s.data), int'(dst_data_i));
          compare("dst_seq_o", int'(s.seq), int'(dst_seq_i));
          // lost total already includes this delivery's gap
          compare("dst_lost_o", exp_lost, int'(dst_lost_i));
        end
      end else if (quiet < `CDC_STALE_CYCLES) begin
        quiet++;
      end
    end
  end

  task automatic after_reset_state();
    int n;
    n = 0;
    compare("dst_valid_o", 0, int'(dst_valid_i));
    compare("dst_stale_o", 0, int'(dst_stale_i));
    compare("src_drops_o", 0, int'(src_drops_i));
    compare("dst_lost_o", 0, int'(dst_lost_i));
    // ready may take up to two source cycles
    while (!src_ready_i && n < 2) begin
      @(negedge clk_src_i);
      n++;
    end
    if (!src_ready_i) begin
      err_count++;
      $display("%s: src_ready_o stayed low two source cycles after reset", cur_test);
    end
  endtask

  task automatic totals(input int exp_drops);
    compare("src_drops_o", exp_drops, int'(src_drops_i));
    compare("dst_lost_o", exp_lost, int'(dst_lost_i));
  endtask

  task automatic stale_level(input int level);
    compare("dst_stale_o", level, int'(dst_stale_i));
  endtask

  // every accepted push delivered once with nothing left over
  task automatic transfer_balance();
    compare("delivery count", accepted, delivered);
    compare("model queue size", 0, exp_q.size());
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_errs = err_count;
    test_count++;
  endtask

  task automatic end_test();
    if (err_count == test_errs) begin
      $display("test %s: passed", cur_test);
    end else begin
      $display("test %s: failed with %0d errors", cur_test, err_count - test_errs);
    end
  endtask

  task automatic summarize();
    $display("%0d tests, %0d deliveries, %0d errors", test_count, delivered, err_count);
  endtask

endmodule

/* tests/tb_cdc_sample_link.sv */
`timescale 1ns/1ns
`include "cdc_link_defs.svh"

module tb_cdc_sample_link;

  localparam int PUSHES = 40;
  // generous bound in dst cycles for one transfer through the crossing
  localparam int XFER_CYCLES = 16;
  localparam int LEN_RESET = 8;
  localparam int LEN_POLITE = PUSHES * XFER_CYCLES;
  localparam int LEN_IGNORED = PUSHES * 4 + XFER_CYCLES;
  localparam int LEN_STALE = `CDC_STALE_CYCLES + 2 * XFER_CYCLES;
  localparam int TIMEOUT = 4 * (LEN_RESET + LEN_POLITE + LEN_IGNORED + LEN_STALE);

  logic                      clk_src = 1'b0;
  logic                      clk_dst = 1'b0;
  logic                      rst = 1'b1;
  logic                      src_push = 1'b0;
  logic [`CDC_DATA_BITS-1:0] src_data = '0;
  logic                      src_ready;
  logic [7:0]                src_drops;
  logic                      dst_valid;
  logic [`CDC_DATA_BITS-1:0] dst_data;
  logic [`CDC_SEQ_BITS-1:0]  dst_seq;
  logic [7:0]                dst_lost;
  logic                      dst_stale;

  integer                    seed = 65;
  // sender model with tag, drop count and drops since the last accept
  logic [`CDC_SEQ_BITS-1:0]  model_seq;
  int                        model_drops;
  int                        drops_since;
  int                        cycles = 0;

  always #7 clk_src = ~clk_src;
  always #10 clk_dst = ~clk_dst;

  cdc_sample_link u_cdc_sample_link (
    .clk_src_i   (clk_src),
    .clk_dst_i   (clk_dst),
    .rst_i       (rst),
    .src_push_i  (src_push),
    .src_data_i  (src_data),
    .src_ready_o (src_ready),
    .src_drops_o (src_drops),
    .dst_valid_o (dst_valid),
    .dst_data_o  (dst_data),
    .dst_seq_o   (dst_seq),
    .dst_lost_o  (dst_lost),
    .dst_stale_o (dst_stale)
  );

  link_checker u_link_checker (
    .clk_src_i   (clk_src),
    .clk_dst_i   (clk_dst),
    .rst_i       (rst),
    .src_ready_i (src_ready),
    .src_drops_i (src_drops),
    .dst_valid_i (dst_valid),
    .dst_data_i  (dst_data),
    .dst_seq_i   (dst_seq),
    .dst_lost_i  (dst_lost),
    .dst_stale_i (dst_stale)
  );

  // a push counts only while ready and every push takes a tag
  always @(posedge clk_src) begin
    if (rst) begin
      model_seq = '0;
      model_drops = 0;
      drops_since = 0;
    end else if (src_push) begin
      if (src_ready) begin
        u_link_checker.expect_sample(model_seq, src_data, drops_since);
        drops_since = 0;
      end else begin
        model_drops++;
        drops_since++;
      end
      model_seq = model_seq + `CDC_SEQ_BITS'(1);
    end
  end

  always @(posedge clk_dst) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the run took more than %0d destination cycles", TIMEOUT);
      $display("Finished with errors");
      $finish;
    end
  end

  // one push strobe, called on a falling source edge
  task automatic push_word();
    src_push = 1'b1;
    src_data = `CDC_DATA_BITS'($random(seed));
    @(negedge clk_src);
    src_push = 1'b0;
  endtask

  task automatic wait_ready();
    while (!src_ready) begin
      @(negedge clk_src);
    end
  endtask

  // the sender is idle only once the last ack has returned
  // the ack leaves the destination together with the valid pulse
  task automatic drain_link();
    while (!src_ready) begin
      @(negedge clk_src);
    end
    // settle away from dst edges
    @(negedge clk_dst);
  endtask

  initial begin : main
    int i;
    int n;
    repeat (5) @(posedge clk_dst);
    @(negedge clk_dst);
    rst = 1'b0;
    u_link_checker.begin_test("after_reset");
    u_link_checker.after_reset_state();
    u_link_checker.end_test();

    u_link_checker.begin_test("polite_pushes");
    for (i = 0; i < PUSHES; i++) begin
      @(negedge clk_src);
      wait_ready();
      push_word();
    end
    drain_link();
    u_link_checker.totals(model_drops);
    u_link_checker.end_test();

    // pushes on random cycles with back to back pushes allowed
    u_link_checker.begin_test("ignored_ready");
    n = 0;
    while (n < PUSHES) begin
      @(negedge clk_src);
      src_push = (($unsigned($random(seed)) % 3) == 0);
      if (src_push) begin
        src_data = `CDC_DATA_BITS'($random(seed));
        n++;
      end
    end
    @(negedge clk_src);
    src_push = 1'b0;
    drain_link();
    u_link_checker.totals(model_drops);
    u_link_checker.end_test();

    // quiet period past the limit, then one delivery clears the flag
    u_link_checker.begin_test("stale_flag");
    repeat (`CDC_STALE_CYCLES + 8) @(negedge clk_dst);
    u_link_checker.stale_level(1);
    @(negedge clk_src);
    wait_ready();
    push_word();
    drain_link();
    repeat (2) @(negedge clk_dst);
    u_link_checker.stale_level(0);
    u_link_checker.end_test();

    u_link_checker.begin_test("no_duplicates");
    u_link_checker.transfer_balance();
    u_link_checker.end_test();

    u_link_checker.summarize();
    if (u_link_checker.err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+hdl
hdl/cdc_link_pkg.sv
hdl/handshake_cdc.sv
hdl/send_fsm.sv
hdl/stale_timer.sv
hdl/dst_capture.sv
hdl/cdc_sample_link.sv
tests/link_checker.sv
tests/tb_cdc_sample_link.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and pass only when the testbench reports success
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal -f build.f --top-module tb_cdc_sample_link -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Finished with no errors" ||
{ echo "simulation failed"; exit 1; }
